//--- fe_cfg.svh
/*
 * Front-end configuration
 * Address and data width, instruction width and issue queue size
 */

`ifndef FE_CFG_SVH
`define FE_CFG_SVH

// ------------------------------
// Datapath widths
// ------------------------------
// RV64 addresses and data
`define XLEN 64
// Uncompressed instruction word
`define ILEN 32

// ------------------------------
// Buffering
// ------------------------------
// Entries between fetch and decode
`define IQ_DEPTH 4

`endif

//--- fe_pkg.sv
/*
 * Front-end package
 * Exception causes, opcodes, decoded operation classes, the issue queue
 * entry and the immediate extraction helpers shared by fetch and decode
 */

`include "fe_cfg.svh"

package fe_pkg;

  // ------------------------------
  // Exception causes
  // ------------------------------
  // Values follow the RISC-V mcause numbering
  typedef enum logic [3:0] {
    EXC_INSTR_MISALIGNED   = 4'd0,
    EXC_INSTR_ACCESS_FAULT = 4'd1,
    EXC_ILLEGAL_INSTR      = 4'd2,
    // No cause, only seen with except_raised low
    EXC_NONE               = 4'hf
  } except_code_t;

  // ------------------------------
  // Major opcodes, bits [6:0]
  // ------------------------------
  typedef enum logic [6:0] {
    OPC_LOAD       = 7'b0000011,
    OPC_OP_IMM     = 7'b0010011,
    OPC_AUIPC      = 7'b0010111,
    OPC_OP_IMM_32  = 7'b0011011,
    OPC_STORE      = 7'b0100011,
    OPC_OP         = 7'b0110011,
    OPC_LUI        = 7'b0110111,
    OPC_OP_32      = 7'b0111011,
    OPC_BRANCH     = 7'b1100011,
    OPC_JALR       = 7'b1100111,
    OPC_JAL        = 7'b1101111,
    OPC_SYSTEM     = 7'b1110011
  } opcode_t;

  // ------------------------------
  // Decoded operation classes
  // ------------------------------
  typedef enum logic [3:0] {
    OP_ALU,
    OP_ALU_IMM,
    OP_LOAD,
    OP_STORE,
    OP_BRANCH,
    OP_JAL,
    OP_JALR,
    OP_LUI,
    OP_AUIPC,
    OP_SYSTEM,
    OP_ILLEGAL
  } op_class_t;

  // ------------------------------
  // Issue queue entry
  // ------------------------------
  typedef struct packed {
    logic [`XLEN-1:0] curr_pc;
    logic [`ILEN-1:0] instruction;
    // Next fetch address chosen by the static predictor
    logic [`XLEN-1:0] pred_target;
    logic             pred_taken;
    logic             except_raised;
    except_code_t     except_code;
  } iq_entry_t;

  // ------------------------------
  // Sign-extended immediates
  // ------------------------------
  // I-type, loads, OP-IMM, JALR and SYSTEM
  function automatic logic [`XLEN-1:0] imm_i(input logic [`ILEN-1:0] instr);
    return {{(`XLEN-12){instr[31]}}, instr[31:20]};
  endfunction

  // S-type, stores
  function automatic logic [`XLEN-1:0] imm_s(input logic [`ILEN-1:0] instr);
    return {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
  endfunction

  // B-type, always even
  function automatic logic [`XLEN-1:0] imm_b(input logic [`ILEN-1:0] instr);
    return {{(`XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  endfunction

  // U-type, upper 20 bits
  function automatic logic [`XLEN-1:0] imm_u(input logic [`ILEN-1:0] instr);
    return {{(`XLEN-32){instr[31]}}, instr[31:12], 12'b0};
  endfunction

  // J-type, always even
  function automatic logic [`XLEN-1:0] imm_j(input logic [`ILEN-1:0] instr);
    return {{(`XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  endfunction

endpackage

//--- sync_fifo.sv
/*
 * Synchronous first-word-fall-through FIFO
 * Circular buffer with flush and valid/ready on both sides
 */

`timescale 1ns/10ps

`include "fe_cfg.svh"

module sync_fifo import fe_pkg::*; #(
  parameter type         DATA_T = iq_entry_t,
  parameter int unsigned DEPTH  = `IQ_DEPTH
) (
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  flush_i,

  // Write side
  input  logic  valid_i,
  output logic  ready_o,
  input  DATA_T data_i,

  // Read side
  output logic  valid_o,
  input  logic  ready_i,
  output DATA_T data_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  // ------------------------------
  // Storage and pointers
  // ------------------------------
  DATA_T            mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  logic empty;
  logic full;
  logic push;
  logic pop;

  assign empty = (count_q == '0);
  assign full  = (count_q == CNT_W'(DEPTH));

  // Head is presented as soon as it is written
  assign valid_o = !empty;
  assign data_o  = mem_q[rd_ptr_q];

  // A full FIFO still takes a word when the head leaves in the same cycle
  assign ready_o = !full || ready_i;

  assign push = valid_i && ready_o;
  assign pop  = valid_o && ready_i;

  // Pointer increment with wrap at DEPTH
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // ------------------------------
  // Control state
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // Count moves only when one side is idle
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Payload written into the slot under the write pointer
  always_ff @(posedge clk_i) begin
    if (push && !flush_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

//--- fetch_stage.sv
/*
 * Fetch stage
 * Keeps the PC, requests instruction words, predicts branches statically
 * and holds the fetched instruction in a one-entry output register
 */

`timescale 1ns/10ps

`include "fe_cfg.svh"

module fetch_stage import fe_pkg::*; (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             flush_i,
  input  logic [`XLEN-1:0] redirect_pc_i,

  // Instruction memory port
  output logic [`XLEN-1:0] imem_addr_o,
  input  logic             imem_valid_i,
  output logic             imem_ready_o,
  input  logic [`ILEN-1:0] imem_instr_i,
  input  logic             imem_error_i,

  // Towards the issue queue
  output logic             fetch_valid_o,
  input  logic             fetch_ready_i,
  output logic [`XLEN-1:0] curr_pc_o,
  output logic [`ILEN-1:0] instruction_o,
  output logic [`XLEN-1:0] pred_target_o,
  output logic             pred_taken_o,
  output logic             except_raised_o,
  output except_code_t     except_code_o
);

  // ------------------------------
  // Program counter
  // ------------------------------
  logic [`XLEN-1:0] pc_q;
  logic [`XLEN-1:0] pc_plus4;
  logic [`XLEN-1:0] taken_target;
  logic [`XLEN-1:0] next_pc;

  // Output register
  logic             out_valid_q;
  logic [`XLEN-1:0] out_pc_q;
  logic [`ILEN-1:0] out_instr_q;
  logic [`XLEN-1:0] out_target_q;
  logic             out_taken_q;
  logic             out_exc_q;
  except_code_t     out_code_q;

  // Fetch-time decode
  opcode_t          opcode;
  logic             is_branch;
  logic             is_jal;
  logic             pc_misaligned;
  logic             fetch_fault;
  logic             predict_taken;
  except_code_t     fetch_code;
  logic             mem_accept;

  // Memory always sees the current PC
  assign imem_addr_o = pc_q;

  // Accept when the output slot is free or drains this cycle
  assign imem_ready_o = !out_valid_q || fetch_ready_i;
  assign mem_accept   = imem_valid_i && imem_ready_o;

  // ------------------------------
  // Static prediction
  // ------------------------------
  assign opcode    = opcode_t'(imem_instr_i[6:0]);
  assign is_branch = (opcode == OPC_BRANCH);
  assign is_jal    = (opcode == OPC_JAL);

  assign pc_plus4 = pc_q + `XLEN'(4);
  // JAL uses its J offset, conditional branches their B offset
  assign taken_target = pc_q + (is_jal ? imm_j(imem_instr_i) : imm_b(imem_instr_i));

  // Misaligned PC or a bus error
  assign pc_misaligned = |pc_q[1:0];
  assign fetch_fault   = pc_misaligned || imem_error_i;

  // Backward branches (negative offset, sign bit 31) and JAL go taken
  // Faulting fetches never redirect
  assign predict_taken = !fetch_fault && (is_jal || (is_branch && imem_instr_i[31]));
  assign next_pc       = predict_taken ? taken_target : pc_plus4;

  // Misalignment wins over an access fault on the same fetch
  always_comb begin
    if (pc_misaligned) begin
      fetch_code = EXC_INSTR_MISALIGNED;
    end else if (imem_error_i) begin
      fetch_code = EXC_INSTR_ACCESS_FAULT;
    end else begin
      fetch_code = EXC_NONE;
    end
  end

  // ------------------------------
  // PC and output valid
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_q        <= '0;
      out_valid_q <= 1'b0;
    end else if (flush_i) begin
      pc_q        <= redirect_pc_i;
      out_valid_q <= 1'b0;
    end else if (mem_accept) begin
      pc_q        <= next_pc;
      out_valid_q <= 1'b1;
    end else if (fetch_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  // Output payload, loaded with each accepted answer
  always_ff @(posedge clk_i) begin
    if (mem_accept) begin
      out_pc_q     <= pc_q;
      out_instr_q  <= imem_instr_i;
      out_target_q <= next_pc;
      out_taken_q  <= predict_taken;
      out_exc_q    <= fetch_fault;
      out_code_q   <= fetch_code;
    end
  end

  assign fetch_valid_o   = out_valid_q;
  assign curr_pc_o       = out_pc_q;
  assign instruction_o   = out_instr_q;
  assign pred_target_o   = out_target_q;
  assign pred_taken_o    = out_taken_q;
  assign except_raised_o = out_exc_q;
  assign except_code_o   = out_code_q;

endmodule

//--- issue_queue.sv
/*
 * Issue queue
 * Buffers fetched instructions in a FIFO until decode takes them
 */

`timescale 1ns/10ps

`include "fe_cfg.svh"

module issue_queue import fe_pkg::*; (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             flush_i,

  // Fetch side handshake
  input  logic             fetch_valid_i,
  output logic             fetch_ready_o,

  // Fetched instruction
  input  logic [`XLEN-1:0] curr_pc_i,
  input  logic [`ILEN-1:0] instruction_i,
  input  logic [`XLEN-1:0] pred_target_i,
  input  logic             pred_taken_i,
  input  logic             except_raised_i,
  input  except_code_t     except_code_i,

  // Decode side handshake
  input  logic             issue_ready_i,
  output logic             issue_valid_o,

  // Head of the queue
  output logic [`XLEN-1:0] curr_pc_o,
  output logic [`ILEN-1:0] instruction_o,
  output logic [`XLEN-1:0] pred_target_o,
  output logic             pred_taken_o,
  output logic             except_raised_o,
  output except_code_t     except_code_o
);

  iq_entry_t new_entry;
  iq_entry_t head_entry;

  // ------------------------------
  // Entry packing
  // ------------------------------
  assign new_entry.curr_pc       = curr_pc_i;
  assign new_entry.instruction   = instruction_i;
  assign new_entry.pred_target   = pred_target_i;
  assign new_entry.pred_taken    = pred_taken_i;
  assign new_entry.except_raised = except_raised_i;
  assign new_entry.except_code   = except_code_i;

  sync_fifo #(
    .DATA_T(iq_entry_t),
    .DEPTH (`IQ_DEPTH)
  ) u_iq_fifo (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .flush_i(flush_i),
    .valid_i(fetch_valid_i),
    .ready_o(fetch_ready_o),
    .data_i (new_entry),
    .valid_o(issue_valid_o),
    .ready_i(issue_ready_i),
    .data_o (head_entry)
  );

  // Unpack the head for decode
  assign curr_pc_o       = head_entry.curr_pc;
  assign instruction_o   = head_entry.instruction;
  assign pred_target_o   = head_entry.pred_target;
  assign pred_taken_o    = head_entry.pred_taken;
  assign except_raised_o = head_entry.except_raised;
  assign except_code_o   = head_entry.except_code;

endmodule

//--- issue_decode.sv
/*
 * Issue decode stage
 * Registered decode of operation class, register indices, immediate and
 * the final exception of each queued instruction
 */

`timescale 1ns/10ps

`include "fe_cfg.svh"

module issue_decode import fe_pkg::*; (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             flush_i,

  // From the issue queue
  input  logic             iq_valid_i,
  output logic             iq_ready_o,
  input  logic [`XLEN-1:0] curr_pc_i,
  input  logic [`ILEN-1:0] instruction_i,
  input  logic [`XLEN-1:0] pred_target_i,
  input  logic             pred_taken_i,
  input  logic             except_raised_i,
  input  except_code_t     except_code_i,

  // Decoded instruction
  output logic             issue_valid_o,
  input  logic             issue_ready_i,
  output op_class_t        op_class_o,
  output logic [4:0]       rd_o,
  output logic [4:0]       rs1_o,
  output logic [4:0]       rs2_o,
  output logic [`XLEN-1:0] imm_o,
  output logic [`XLEN-1:0] pc_o,
  output logic             pred_taken_o,
  output logic [`XLEN-1:0] pred_target_o,
  output logic             except_raised_o,
  output except_code_t     except_code_o
);

  opcode_t          opcode;
  op_class_t        dec_class;
  logic [`XLEN-1:0] dec_imm;
  logic             use_rd;
  logic             use_rs1;
  logic             use_rs2;
  logic             dec_exc;
  except_code_t     dec_code;
  logic             accept;
  logic             valid_q;

  assign opcode = opcode_t'(instruction_i[6:0]);

  // ------------------------------
  // Opcode to class and immediate
  // ------------------------------
  always_comb begin
    dec_class = OP_ILLEGAL;
    dec_imm   = '0;
    use_rd    = 1'b0;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    case (opcode)
      // Register-register, 64 and 32 bit forms
      OPC_OP, OPC_OP_32: begin
        dec_class = OP_ALU;
        use_rd    = 1'b1;
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
      end
      OPC_OP_IMM, OPC_OP_IMM_32: begin
        dec_class = OP_ALU_IMM;
        dec_imm   = imm_i(instruction_i);
        use_rd    = 1'b1;
        use_rs1   = 1'b1;
      end
      OPC_LOAD: begin
        dec_class = OP_LOAD;
        dec_imm   = imm_i(instruction_i);
        use_rd    = 1'b1;
        use_rs1   = 1'b1;
      end
      OPC_STORE: begin
        dec_class = OP_STORE;
        dec_imm   = imm_s(instruction_i);
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
      end
      OPC_BRANCH: begin
        dec_class = OP_BRANCH;
        dec_imm   = imm_b(instruction_i);
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
      end
      OPC_JAL: begin
        dec_class = OP_JAL;
        dec_imm   = imm_j(instruction_i);
        use_rd    = 1'b1;
      end
      OPC_JALR: begin
        dec_class = OP_JALR;
        dec_imm   = imm_i(instruction_i);
        use_rd    = 1'b1;
        use_rs1   = 1'b1;
      end
      OPC_LUI: begin
        dec_class = OP_LUI;
        dec_imm   = imm_u(instruction_i);
        use_rd    = 1'b1;
      end
      OPC_AUIPC: begin
        dec_class = OP_AUIPC;
        dec_imm   = imm_u(instruction_i);
        use_rd    = 1'b1;
      end
      // CSR access and ECALL/EBREAK, CSR number rides in the I immediate
      OPC_SYSTEM: begin
        dec_class = OP_SYSTEM;
        dec_imm   = imm_i(instruction_i);
        use_rd    = 1'b1;
        use_rs1   = 1'b1;
      end
      default: begin
        dec_class = OP_ILLEGAL;
      end
    endcase
  end

  // Fetch exceptions pass untouched, otherwise flag unknown opcodes
  always_comb begin
    if (except_raised_i) begin
      dec_exc  = 1'b1;
      dec_code = except_code_i;
    end else if (dec_class == OP_ILLEGAL) begin
      dec_exc  = 1'b1;
      dec_code = EXC_ILLEGAL_INSTR;
    end else begin
      dec_exc  = 1'b0;
      dec_code = EXC_NONE;
    end
  end

  // ------------------------------
  // Pipeline register
  // ------------------------------
  assign iq_ready_o = !valid_q || issue_ready_i;
  assign accept     = iq_valid_i && iq_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (issue_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // Unused register fields read as x0
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_class_o      <= dec_class;
      rd_o            <= use_rd ? instruction_i[11:7] : 5'd0;
      rs1_o           <= use_rs1 ? instruction_i[19:15] : 5'd0;
      rs2_o           <= use_rs2 ? instruction_i[24:20] : 5'd0;
      imm_o           <= dec_imm;
      pc_o            <= curr_pc_i;
      pred_taken_o    <= pred_taken_i;
      pred_target_o   <= pred_target_i;
      except_raised_o <= dec_exc;
      except_code_o   <= dec_code;
    end
  end

  assign issue_valid_o = valid_q;

endmodule

//--- frontend_top.sv
/*
 * Front-end top level
 * Fetch, issue queue and decode in a row with one shared flush
 */

`timescale 1ns/10ps

`include "fe_cfg.svh"

module frontend_top import fe_pkg::*; (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             flush_i,
  input  logic [`XLEN-1:0] redirect_pc_i,

  // Instruction memory port
  output logic [`XLEN-1:0] imem_addr_o,
  input  logic             imem_valid_i,
  output logic             imem_ready_o,
  input  logic [`ILEN-1:0] imem_instr_i,
  input  logic             imem_error_i,

  // Decoded instruction
  output logic             issue_valid_o,
  input  logic             issue_ready_i,
  output op_class_t        op_class_o,
  output logic [4:0]       rd_o,
  output logic [4:0]       rs1_o,
  output logic [4:0]       rs2_o,
  output logic [`XLEN-1:0] imm_o,
  output logic [`XLEN-1:0] pc_o,
  output logic             pred_taken_o,
  output logic [`XLEN-1:0] pred_target_o,
  output logic             except_raised_o,
  output except_code_t     except_code_o
);

  // ------------------------------
  // Fetch to queue
  // ------------------------------
  logic             fetch_valid;
  logic             fetch_ready;
  logic [`XLEN-1:0] fetch_pc;
  logic [`ILEN-1:0] fetch_instr;
  logic [`XLEN-1:0] fetch_target;
  logic             fetch_taken;
  logic             fetch_exc;
  except_code_t     fetch_code;

  // ------------------------------
  // Queue to decode
  // ------------------------------
  logic             iq_valid;
  logic             iq_ready;
  logic [`XLEN-1:0] iq_pc;
  logic [`ILEN-1:0] iq_instr;
  logic [`XLEN-1:0] iq_target;
  logic             iq_taken;
  logic             iq_exc;
  except_code_t     iq_code;

  fetch_stage u_fetch (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .flush_i        (flush_i),
    .redirect_pc_i  (redirect_pc_i),
    .imem_addr_o    (imem_addr_o),
    .imem_valid_i   (imem_valid_i),
    .imem_ready_o   (imem_ready_o),
    .imem_instr_i   (imem_instr_i),
    .imem_error_i   (imem_error_i),
    .fetch_valid_o  (fetch_valid),
    .fetch_ready_i  (fetch_ready),
    .curr_pc_o      (fetch_pc),
    .instruction_o  (fetch_instr),
    .pred_target_o  (fetch_target),
    .pred_taken_o   (fetch_taken),
    .except_raised_o(fetch_exc),
    .except_code_o  (fetch_code)
  );

  issue_queue u_iq (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .flush_i        (flush_i),
    .fetch_valid_i  (fetch_valid),
    .fetch_ready_o  (fetch_ready),
    .curr_pc_i      (fetch_pc),
    .instruction_i  (fetch_instr),
    .pred_target_i  (fetch_target),
    .pred_taken_i   (fetch_taken),
    .except_raised_i(fetch_exc),
    .except_code_i  (fetch_code),
    .issue_ready_i  (iq_ready),
    .issue_valid_o  (iq_valid),
    .curr_pc_o      (iq_pc),
    .instruction_o  (iq_instr),
    .pred_target_o  (iq_target),
    .pred_taken_o   (iq_taken),
    .except_raised_o(iq_exc),
    .except_code_o  (iq_code)
  );

  issue_decode u_decode (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .flush_i        (flush_i),
    .iq_valid_i     (iq_valid),
    .iq_ready_o     (iq_ready),
    .curr_pc_i      (iq_pc),
    .instruction_i  (iq_instr),
    .pred_target_i  (iq_target),
    .pred_taken_i   (iq_taken),
    .except_raised_i(iq_exc),
    .except_code_i  (iq_code),
    .issue_valid_o  (issue_valid_o),
    .issue_ready_i  (issue_ready_i),
    .op_class_o     (op_class_o),
    .rd_o           (rd_o),
    .rs1_o          (rs1_o),
    .rs2_o          (rs2_o),
    .imm_o          (imm_o),
    .pc_o           (pc_o),
    .pred_taken_o   (pred_taken_o),
    .pred_target_o  (pred_target_o),
    .except_raised_o(except_raised_o),
    .except_code_o  (except_code_o)
  );

endmodule

//--- tb_frontend.sv
/*
 * Front-end testbench
 * Program table as instruction memory, static prediction model,
 * random memory and issue back-pressure, flush and redirect checks
 */

`timescale 1ns/10ps

`include "fe_cfg.svh"

module tb_frontend import fe_pkg::*;;

  localparam int PROG_ROWS  = 14;
  localparam int IDLE_LIMIT = 40;
  // Run length limit in clock cycles
  localparam int MAX_CYCLES = (PROG_ROWS + 2 * `IQ_DEPTH) * 20;

  // ------------------------------
  // Table and model types
  // ------------------------------
  typedef struct packed {
    logic [`ILEN-1:0] instr;
    bit               err;
    op_class_t        cls;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [`XLEN-1:0] imm;
  } row_t;

  typedef struct packed {
    int               idx;
    logic [`XLEN-1:0] pc;
    bit               taken;
    logic [`XLEN-1:0] target;
    bit               exc;
    except_code_t     code;
  } exp_t;

  // DUT ports
  logic             clk_i;
  logic             reset_i;
  logic             flush_i;
  logic [`XLEN-1:0] redirect_pc_i;
  logic [`XLEN-1:0] imem_addr_o;
  logic             imem_valid_i;
  logic             imem_ready_o;
  logic [`ILEN-1:0] imem_instr_i;
  logic             imem_error_i;
  logic             issue_valid_o;
  logic             issue_ready_i;
  op_class_t        op_class_o;
  logic [4:0]       rd_o;
  logic [4:0]       rs1_o;
  logic [4:0]       rs2_o;
  logic [`XLEN-1:0] imm_o;
  logic [`XLEN-1:0] pc_o;
  logic             pred_taken_o;
  logic [`XLEN-1:0] pred_target_o;
  logic             except_raised_o;
  except_code_t     except_code_o;

  row_t   prog [PROG_ROWS];
  exp_t   exp_q [$];
  exp_t   head_exp;
  integer seed = 41;
  int     cycle_count = 0;
  int     issue_count = 0;
  int     mismatch_count = 0;
  int     lost_count = 0;
  int     extra_count = 0;
  int     other_count = 0;

  frontend_top dut0 (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .flush_i        (flush_i),
    .redirect_pc_i  (redirect_pc_i),
    .imem_addr_o    (imem_addr_o),
    .imem_valid_i   (imem_valid_i),
    .imem_ready_o   (imem_ready_o),
    .imem_instr_i   (imem_instr_i),
    .imem_error_i   (imem_error_i),
    .issue_valid_o  (issue_valid_o),
    .issue_ready_i  (issue_ready_i),
    .op_class_o     (op_class_o),
    .rd_o           (rd_o),
    .rs1_o          (rs1_o),
    .rs2_o          (rs2_o),
    .imm_o          (imm_o),
    .pc_o           (pc_o),
    .pred_taken_o   (pred_taken_o),
    .pred_target_o  (pred_target_o),
    .except_raised_o(except_raised_o),
    .except_code_o  (except_code_o)
  );

  // 40 ns clock
  always #20 clk_i = ~clk_i;

  // ------------------------------
  // Program table
  // ------------------------------
  task automatic set_row(input int i, input logic [31:0] instr, input bit err,
                         input op_class_t cls, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2,
                         input logic [63:0] imm);
    prog[i].instr = instr;
    prog[i].err   = err;
    prog[i].cls   = cls;
    prog[i].rd    = rd;
    prog[i].rs1   = rs1;
    prog[i].rs2   = rs2;
    prog[i].imm   = imm;
  endtask

  task automatic load_program();
    // addi x1, x0, 5
    set_row(0, 32'h00500093, 0, OP_ALU_IMM, 5'd1, 5'd0, 5'd0, 64'd5);
    // add x3, x1, x2
    set_row(1, 32'h002081b3, 0, OP_ALU, 5'd3, 5'd1, 5'd2, 64'd0);
    // ld x4, -8(x2)
    set_row(2, 32'hff813203, 0, OP_LOAD, 5'd4, 5'd2, 5'd0, 64'hffff_ffff_ffff_fff8);
    // sd x5, 16(x2)
    set_row(3, 32'h00513823, 0, OP_STORE, 5'd0, 5'd2, 5'd5, 64'd16);
    set_row(4, 32'h12345337, 0, OP_LUI, 5'd6, 5'd0, 5'd0, 64'h0000_0000_1234_5000);
    // Negative U immediate
    set_row(5, 32'h80000397, 0, OP_AUIPC, 5'd7, 5'd0, 5'd0, 64'hffff_ffff_8000_0000);
    // jal x1, +12 over the loop body
    set_row(6, 32'h00c000ef, 0, OP_JAL, 5'd1, 5'd0, 5'd0, 64'd12);
    // Loop body, reached from the backward branch
    set_row(7, 32'h40118433, 0, OP_ALU, 5'd8, 5'd3, 5'd1, 64'd0);
    set_row(8, 32'h0080006f, 0, OP_JAL, 5'd0, 5'd0, 5'd0, 64'd8);
    // beq x1, x2, -8 back to row 7
    set_row(9, 32'hfe208ce3, 0, OP_BRANCH, 5'd0, 5'd1, 5'd2, 64'hffff_ffff_ffff_fff8);
    // bne x3, x0, +8 forward, falls through
    set_row(10, 32'h00019463, 0, OP_BRANCH, 5'd0, 5'd3, 5'd0, 64'd8);
    // Bus error on this word
    set_row(11, 32'h0030e4b3, 1, OP_ALU, 5'd9, 5'd1, 5'd3, 64'd0);
    // csrrs x10, mstatus, x0
    set_row(12, 32'h30002573, 0, OP_SYSTEM, 5'd10, 5'd0, 5'd0, 64'h300);
    // custom-0 opcode, not decoded
    set_row(13, 32'h0000000b, 0, OP_ILLEGAL, 5'd0, 5'd0, 5'd0, 64'd0);
  endtask

  // ------------------------------
  // Reference model
  // ------------------------------
  // Walks the table from start_pc with the static prediction rule
  task automatic build_expected(input logic [63:0] start_pc);
    logic [63:0] pc;
    int          steps;
    int          idx;
    bit          mis;
    exp_t        e;
    pc    = start_pc;
    steps = 0;
    while ((pc >> 2) < 64'(PROG_ROWS) && steps < 4 * PROG_ROWS) begin
      idx   = int'(pc[31:2]);
      mis   = (pc[1:0] != 2'b00);
      e.idx = idx;
      e.pc  = pc;
      // Backward branches and JAL taken, never on a faulting fetch
      e.taken = !mis && !prog[idx].err &&
                (prog[idx].cls == OP_JAL ||
                 (prog[idx].cls == OP_BRANCH && prog[idx].imm[63]));
      e.target = e.taken ? pc + prog[idx].imm : pc + 64'd4;
      if (mis) begin
        e.exc  = 1'b1;
        e.code = EXC_INSTR_MISALIGNED;
      end else if (prog[idx].err) begin
        e.exc  = 1'b1;
        e.code = EXC_INSTR_ACCESS_FAULT;
      end else if (prog[idx].cls == OP_ILLEGAL) begin
        e.exc  = 1'b1;
        e.code = EXC_ILLEGAL_INSTR;
      end else begin
        e.exc  = 1'b0;
        e.code = EXC_NONE;
      end
      exp_q.push_back(e);
      pc = e.target;
      steps++;
    end
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------
  function automatic bit chance(input int pct);
    return ($unsigned($random(seed)) % 100) < pct;
  endfunction

  // Memory answers only inside the table, valid drops out at random
  task automatic drive_inputs(input int mem_pct, input int rdy_pct);
    int idx;
    idx = int'(imem_addr_o[31:2]);
    if ((imem_addr_o >> 2) < 64'(PROG_ROWS)) begin
      imem_instr_i = prog[idx].instr;
      imem_error_i = prog[idx].err;
      imem_valid_i = chance(mem_pct);
    end else begin
      imem_instr_i = '0;
      imem_error_i = 1'b0;
      imem_valid_i = 1'b0;
    end
    issue_ready_i = chance(rdy_pct);
  endtask

  // One-cycle flush, issue side held off so nothing leaves on the flush edge
  task automatic flush_to(input logic [63:0] pc);
    @(negedge clk_i);
    flush_i       = 1'b1;
    redirect_pc_i = pc;
    imem_valid_i  = 1'b0;
    issue_ready_i = 1'b0;
    @(negedge clk_i);
    flush_i = 1'b0;
    assert (imem_addr_o == pc && !issue_valid_o) else begin
      other_count++;
      $display("flush to %h did not empty the pipeline or redirect the PC", pc);
    end
  endtask

  // Run until the model sequence is consumed or the DUT goes quiet
  task automatic run_pass(input int mem_pct, input int rdy_pct);
    int idle;
    int seen;
    idle = 0;
    seen = issue_count;
    while (exp_q.size() != 0 && idle < IDLE_LIMIT) begin
      @(negedge clk_i);
      if (issue_count != seen) begin
        seen = issue_count;
        idle = 0;
      end else begin
        idle++;
      end
      drive_inputs(mem_pct, rdy_pct);
    end
    assert (exp_q.size() == 0) else begin
      lost_count += exp_q.size();
      $display("lost instructions: %0d never issued, first missing pc %h",
               exp_q.size(), exp_q[0].pc);
      exp_q.delete();
    end
  endtask

  // Idle cycles with issue open, catches extra instructions
  task automatic settle(input int n);
    repeat (n) begin
      @(negedge clk_i);
      drive_inputs(100, 100);
    end
  endtask

  // ------------------------------
  // Checker
  // ------------------------------
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    assert (got === expected) else begin
      mismatch_count++;
      $display("mismatch at %0t: %s got %h expected %h (pc %h)",
               $time, name, got, expected, pc_o);
    end
  endtask

  task automatic compare_issue(input exp_t e);
    row_t r;
    r = prog[e.idx];
    check_value("pc", pc_o, e.pc);
    check_value("pred_taken", 64'(pred_taken_o), 64'(e.taken));
    check_value("pred_target", pred_target_o, e.target);
    check_value("op_class", 64'(op_class_o), 64'(r.cls));
    check_value("rd", 64'(rd_o), 64'(r.rd));
    check_value("rs1", 64'(rs1_o), 64'(r.rs1));
    check_value("rs2", 64'(rs2_o), 64'(r.rs2));
    check_value("imm", imm_o, r.imm);
    check_value("except_raised", 64'(except_raised_o), 64'(e.exc));
    check_value("except_code", 64'(except_code_o), 64'(e.code));
  endtask

  // A transfer is valid and ready at the rising edge
  always @(posedge clk_i) begin
    if (!reset_i && issue_valid_o && issue_ready_i) begin
      issue_count++;
      assert (exp_q.size() != 0) else begin
        extra_count++;
        $display("extra instruction issued at %0t with pc %h", $time, pc_o);
      end
      if (exp_q.size() != 0) begin
        head_exp = exp_q.pop_front();
        compare_issue(head_exp);
      end
    end
  end

  // Run limit
  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    clk_i         = 1'b0;
    reset_i       = 1'b1;
    flush_i       = 1'b0;
    redirect_pc_i = '0;
    imem_valid_i  = 1'b0;
    imem_instr_i  = '0;
    imem_error_i  = 1'b0;
    issue_ready_i = 1'b0;
    load_program();

    repeat (8) @(negedge clk_i);
    assert (imem_ready_o && !issue_valid_o && imem_addr_o == '0) else begin
      other_count++;
      $display("reset state wrong: PC not 0, memory not ready or issue valid high");
    end
    reset_i = 1'b0;

    // Straight line, branches, faults, light back-pressure
    build_expected(64'h0);
    run_pass(80, 75);
    settle(10);

    // Fill all stages, then drop them with a flush
    flush_to(64'h0);
    repeat (12) begin
      @(negedge clk_i);
      drive_inputs(100, 0);
    end
    assert (issue_valid_o && !imem_ready_o) else begin
      other_count++;
      $display("pipeline did not fill while issue was held off");
    end
    flush_to(64'h8);
    // Heavy back-pressure from row 2 on
    build_expected(64'h8);
    run_pass(70, 30);
    settle(10);

    // Misaligned redirect into the last row
    flush_to(64'h36);
    build_expected(64'h36);
    run_pass(100, 100);
    settle(10);

    $display("issued %0d, mismatches %0d, lost %0d, extra %0d, other errors %0d",
             issue_count, mismatch_count, lost_count, extra_count, other_count);
    if (mismatch_count + lost_count + extra_count + other_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+.
fe_pkg.sv
sync_fifo.sv
fetch_stage.sv
issue_queue.sv
issue_decode.sv
frontend_top.sv
tb_frontend.sv

//--- Makefile
# Verilator build and run of the front-end testbench

VERILATOR ?= verilator
TOP       ?= tb_frontend
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "TEST FAILED"; exit 1; \
	elif ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "TEST FAILED, no result in $(LOG)"; exit 1; \
	else \
		echo "TEST PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
